/* src/spm_pkg.sv */
`default_nettype none

package spm_pkg;

  // Memory geometry
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned NumBytes      = DataWidth / 8;
  localparam int unsigned NumBanks      = 2;
  localparam int unsigned BankWords     = 256;
  localparam int unsigned AddrWidth     = 11;
  localparam int unsigned WordAddrWidth = 8;

  // Access size of a load or store
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } spm_size_e;

  // External request, one per cycle when valid
  typedef struct packed {
    logic                 valid;
    logic                 we;
    spm_size_e            size;
    logic                 sgn;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } spm_req_t;

  // External response, in request order
  typedef struct packed {
    logic                 valid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } spm_rsp_t;

  // Aligned bank access from the request stage
  typedef struct packed {
    logic                          valid;
    logic                          we;
    logic                          err;
    logic [$clog2(NumBanks)-1:0]   bank;
    logic [WordAddrWidth-1:0]      word_addr;
    logic [NumBytes-1:0]           be;
    logic [DataWidth-1:0]          wdata;
    logic [$clog2(NumBytes)-1:0]   offset;
    spm_size_e                     size;
    logic                          sgn;
  } spm_acc_t;

  // Side info that travels next to the raw read word
  typedef struct packed {
    logic                        valid;
    logic                        we;
    logic                        err;
    logic [$clog2(NumBytes)-1:0] offset;
    spm_size_e                   size;
    logic                        sgn;
  } spm_lane_t;

endpackage

`default_nettype wire

/* src/sram.sv */
`timescale 1ns/1ps
`default_nettype none

module sram #(
  parameter int unsigned NumWords  = 256,
  parameter int unsigned DataWidth = 32
) (
  input  logic                        clk_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] addr_i,
  input  logic [DataWidth-1:0]        wdata_i,
  input  logic [DataWidth/8-1:0]      be_i,
  output logic [DataWidth-1:0]        rdata_o
);

  localparam int unsigned NumBytes = DataWidth / 8;

  logic [DataWidth-1:0] mem_q [NumWords];

  // Read-first port, a read returns the word one cycle later
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int unsigned i = 0; i < NumBytes; i++) begin
          if (be_i[i]) begin
            mem_q[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* src/spm_req_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module spm_req_stage (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  spm_pkg::spm_req_t req_i,
  output spm_pkg::spm_acc_t acc_o
);

  localparam int unsigned OffWidth  = $clog2(spm_pkg::NumBytes);
  localparam int unsigned BankWidth = $clog2(spm_pkg::NumBanks);
  localparam int unsigned NumBytes  = spm_pkg::NumBytes;

  localparam logic [NumBytes-1:0] ByteMask = NumBytes'(1);
  localparam logic [NumBytes-1:0] HalfMask = NumBytes'(3);
  localparam logic [NumBytes-1:0] WordMask = '1;

  logic [OffWidth-1:0] offset;
  logic                misaligned;
  logic [NumBytes-1:0] be;
  logic [spm_pkg::DataWidth-1:0] wdata_rep;

  spm_pkg::spm_acc_t acc_d;
  spm_pkg::spm_acc_t acc_q;
  logic              acc_valid_q;

  assign offset = req_i.addr[OffWidth-1:0];

  // Alignment check and lane mask by access size
  always_comb begin
    misaligned = 1'b0;
    be         = '0;
    wdata_rep  = req_i.wdata;
    case (req_i.size)
      spm_pkg::SIZE_BYTE: begin
        be        = ByteMask << offset;
        wdata_rep = {NumBytes{req_i.wdata[7:0]}};
      end
      spm_pkg::SIZE_HALF: begin
        misaligned = offset[0];
        be         = HalfMask << offset;
        wdata_rep  = {(NumBytes/2){req_i.wdata[15:0]}};
      end
      spm_pkg::SIZE_WORD: begin
        misaligned = (offset != '0);
        be         = WordMask;
      end
      // Reserved size encoding is treated as an error
      default: misaligned = 1'b1;
    endcase
  end

  always_comb begin
    acc_d           = '0;
    acc_d.valid     = req_i.valid;
    acc_d.we        = req_i.we;
    acc_d.err       = req_i.valid & misaligned;
    acc_d.bank      = req_i.addr[OffWidth +: BankWidth];
    acc_d.word_addr = req_i.addr[OffWidth+BankWidth +: spm_pkg::WordAddrWidth];
    // No byte may be written for an erroring access
    acc_d.be        = misaligned ? '0 : be;
    acc_d.wdata     = wdata_rep;
    acc_d.offset    = offset;
    acc_d.size      = req_i.size;
    acc_d.sgn       = req_i.sgn;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_valid_q <= 1'b0;
    end else begin
      acc_valid_q <= acc_d.valid;
    end
  end

  // Payload only moves with a valid request
  always_ff @(posedge clk_i) begin
    if (acc_d.valid) begin
      acc_q <= acc_d;
    end
  end

  always_comb begin
    acc_o       = acc_q;
    acc_o.valid = acc_valid_q;
  end

endmodule

`default_nettype wire

/* src/spm_bank_array.sv */
`timescale 1ns/1ps
`default_nettype none

module spm_bank_array (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  spm_pkg::spm_acc_t             acc_i,
  output spm_pkg::spm_lane_t            lane_o,
  output logic [spm_pkg::DataWidth-1:0] rword_o
);

  localparam int unsigned NumBanks  = spm_pkg::NumBanks;
  localparam int unsigned BankWidth = $clog2(NumBanks);

  logic [NumBanks-1:0]           bank_req;
  logic [spm_pkg::DataWidth-1:0] bank_rdata [NumBanks];
  logic [BankWidth-1:0]          bank_q;
  spm_pkg::spm_lane_t            lane_d;
  spm_pkg::spm_lane_t            lane_q;

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    localparam logic [BankWidth-1:0] BankIdx = BankWidth'(b);

    // Strobe only the addressed bank of a clean access
    assign bank_req[b] = acc_i.valid & ~acc_i.err & (acc_i.bank == BankIdx);

    sram #(
      .NumWords  (spm_pkg::BankWords),
      .DataWidth (spm_pkg::DataWidth)
    ) i_sram (
      .clk_i   (clk_i),
      .req_i   (bank_req[b]),
      .we_i    (acc_i.we),
      .addr_i  (acc_i.word_addr),
      .wdata_i (acc_i.wdata),
      .be_i    (acc_i.be),
      .rdata_o (bank_rdata[b])
    );
  end

  always_comb begin
    lane_d        = '0;
    lane_d.valid  = acc_i.valid;
    lane_d.we     = acc_i.we;
    lane_d.err    = acc_i.err;
    lane_d.offset = acc_i.offset;
    lane_d.size   = acc_i.size;
    lane_d.sgn    = acc_i.sgn;
  end

  // Side info follows the SRAM read by one cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lane_q <= '0;
      bank_q <= '0;
    end else begin
      lane_q <= lane_d;
      bank_q <= acc_i.bank;
    end
  end

  assign lane_o  = lane_q;
  assign rword_o = bank_rdata[bank_q];

endmodule

`default_nettype wire

/* src/spm_resp_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module spm_resp_stage (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  spm_pkg::spm_lane_t            lane_i,
  input  logic [spm_pkg::DataWidth-1:0] rword_i,
  output spm_pkg::spm_rsp_t             rsp_o
);

  localparam int unsigned DataWidth = spm_pkg::DataWidth;

  logic [DataWidth-1:0] shifted;
  logic [DataWidth-1:0] extended;
  logic                 load_ok;
  spm_pkg::spm_rsp_t    rsp_d;
  spm_pkg::spm_rsp_t    rsp_q;

  // Bring the addressed lane down to bit 0
  assign shifted = rword_i >> {lane_i.offset, 3'b000};

  always_comb begin
    case (lane_i.size)
      spm_pkg::SIZE_BYTE: begin
        if (lane_i.sgn) begin
          extended = {{(DataWidth-8){shifted[7]}}, shifted[7:0]};
        end else begin
          extended = {{(DataWidth-8){1'b0}}, shifted[7:0]};
        end
      end
      spm_pkg::SIZE_HALF: begin
        if (lane_i.sgn) begin
          extended = {{(DataWidth-16){shifted[15]}}, shifted[15:0]};
        end else begin
          extended = {{(DataWidth-16){1'b0}}, shifted[15:0]};
        end
      end
      default: extended = shifted;
    endcase
  end

  // Stores and errors return zero data
  assign load_ok = lane_i.valid & ~lane_i.we & ~lane_i.err;

  always_comb begin
    rsp_d       = '0;
    rsp_d.valid = lane_i.valid;
    rsp_d.err   = lane_i.valid & lane_i.err;
    rsp_d.rdata = load_ok ? extended : '0;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

/* src/spm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spm_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  spm_pkg::spm_req_t req_i,
  output spm_pkg::spm_rsp_t rsp_o
);

  spm_pkg::spm_acc_t             acc;
  spm_pkg::spm_lane_t            lane;
  logic [spm_pkg::DataWidth-1:0] rword;

  // Stage 1, alignment and lane setup
  spm_req_stage i_spm_req_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .acc_o    (acc)
  );

  // Stage 2, bank select and SRAM access
  spm_bank_array i_spm_bank_array (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .acc_i    (acc),
    .lane_o   (lane),
    .rword_o  (rword)
  );

  // Stage 3, load extraction and response
  spm_resp_stage i_spm_resp_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .lane_i   (lane),
    .rword_i  (rword),
    .rsp_o    (rsp_o)
  );

endmodule

`default_nettype wire

/* bench/spm_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module spm_clkgen #(
  parameter int unsigned HalfPeriodNs = 20,
  parameter int unsigned ResetCycles  = 4
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  // Reset drops at time zero and lifts just after the last reset edge
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/spm_props.sv */
`timescale 1ns/1ps
`default_nettype none

module spm_props (
  input logic                         clk_i,
  input logic                         arst_n_i,
  input spm_pkg::spm_req_t            req_i,
  input spm_pkg::spm_rsp_t            rsp_i,
  input spm_pkg::spm_acc_t            acc_i,
  input logic [spm_pkg::NumBanks-1:0] bank_req_i
);

  // Every request comes back exactly three cycles later
  a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_i.valid == $past(req_i.valid, 3))
    else $error("rsp_o.valid does not follow req_i.valid by three cycles");

  a_err_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rsp_i.valid && rsp_i.err) |-> (rsp_i.rdata == '0))
    else $error("erroring response carries nonzero rdata");

  // A misaligned access must leave both banks idle
  a_err_no_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (acc_i.valid && acc_i.err) |-> (bank_req_i == '0))
    else $error("bank strobed for an erroring access");

endmodule

bind spm_top spm_props i_spm_props (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .req_i      (req_i),
  .rsp_i      (rsp_o),
  .acc_i      (acc),
  .bank_req_i (i_spm_bank_array.bank_req)
);

`default_nettype wire

/* bench/spm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module spm_tb;

  localparam int unsigned FillWords  = 2 * spm_pkg::BankWords;
  localparam int unsigned SubStores  = 64;
  localparam int unsigned SubLoads   = 128;
  localparam int unsigned MisCount   = 32;
  localparam int unsigned StreamLen  = 2000;
  localparam int unsigned TotalReqs  = 2 * FillWords + 2 * SubStores + SubLoads
                                       + 2 * MisCount + StreamLen;
  localparam int unsigned CycleLimit = TotalReqs + 100;
  localparam int unsigned MemBytes   = 1 << spm_pkg::AddrWidth;
  localparam int unsigned Latency    = 3;

  logic              clk;
  logic              arst_n;
  spm_pkg::spm_req_t req;
  spm_pkg::spm_rsp_t rsp;

  logic [7:0]        model_mem [MemBytes];
  spm_pkg::spm_rsp_t exp_q [$];
  int unsigned       issue_q [$];
  int unsigned       cycle = 0;
  int unsigned       n_checks = 0;
  int unsigned       n_errors = 0;

  spm_clkgen i_spm_clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  spm_top i_spm_top (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .req_i    (req),
    .rsp_o    (rsp)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", CycleLimit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic spm_pkg::spm_req_t make_req(input logic we, input spm_pkg::spm_size_e size,
      input logic sgn, input logic [spm_pkg::AddrWidth-1:0] addr, input logic [31:0] wdata);
    spm_pkg::spm_req_t r;
    r       = '0;
    r.valid = 1'b1;
    r.we    = we;
    r.size  = size;
    r.sgn   = sgn;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  // Little-endian byte memory, updated in request order
  task automatic model_apply(input spm_pkg::spm_req_t r, output spm_pkg::spm_rsp_t e);
    int                            nbytes;
    logic                          bad;
    logic [31:0]                   val;
    logic [spm_pkg::AddrWidth-1:0] ba;
    nbytes = (r.size == spm_pkg::SIZE_BYTE) ? 1 : (r.size == spm_pkg::SIZE_HALF) ? 2 : 4;
    bad    = (nbytes == 2 && r.addr[0]) || (nbytes == 4 && r.addr[1:0] != 2'b00);
    val    = '0;
    e       = '0;
    e.valid = 1'b1;
    e.err   = bad;
    for (int i = 0; i < nbytes; i++) begin
      ba = r.addr + spm_pkg::AddrWidth'(i);
      if (!bad && r.we) begin
        model_mem[ba] = r.wdata[8*i +: 8];
      end
      val[8*i +: 8] = model_mem[ba];
    end
    if (r.sgn && nbytes == 1 && val[7]) val[31:8] = '1;
    if (r.sgn && nbytes == 2 && val[15]) val[31:16] = '1;
    if (!bad && !r.we) e.rdata = val;
  endtask

  task automatic send(input spm_pkg::spm_req_t r);
    spm_pkg::spm_rsp_t e;
    @(posedge clk);
    #2;
    req = r;
    model_apply(r, e);
    exp_q.push_back(e);
    issue_q.push_back(cycle);
  endtask

  task automatic check_rsp(input spm_pkg::spm_rsp_t got, input spm_pkg::spm_rsp_t expd);
    n_checks++;
    if (got !== expd) begin
      n_errors++;
      $display("ERR rsp_o: got %h expected %h (rdata %h vs %h)",
               got, expd, got.rdata, expd.rdata);
    end
  endtask

  task automatic check_err(input logic got, input logic expd);
    n_checks++;
    if (got !== expd) begin
      n_errors++;
      $display("ERR rsp_o.err: got %h expected %h", got, expd);
    end
  endtask

  // Outputs are looked at on the falling edge, away from the drive point
  always @(negedge clk) begin : monitor
    spm_pkg::spm_rsp_t expd;
    int unsigned       sent;
    if (arst_n && rsp.valid) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("Response at cycle %0d arrived with no request outstanding", cycle);
      end else begin
        expd = exp_q.pop_front();
        sent = issue_q.pop_front();
        if (cycle != sent + Latency) begin
          n_errors++;
          $display("Response for the request of cycle %0d came at cycle %0d", sent, cycle);
        end
        check_err(rsp.err, expd.err);
        check_rsp(rsp, expd);
      end
    end
  end

  task automatic finish_test(input string name, input int unsigned errs_before);
    @(posedge clk);
    #2;
    req = '0;
    while (exp_q.size() != 0) @(posedge clk);
    $display("test %-10s %s, %0d errors", name,
             (n_errors == errs_before) ? "ok" : "mismatch", n_errors - errs_before);
  endtask

  initial begin
    int unsigned                   errs;
    logic [31:0]                   rnd;
    logic [1:0]                    off;
    logic [8:0]                    widx;
    logic [8:0]                    hot [4];
    logic [spm_pkg::AddrWidth-1:0] touched [SubStores];
    spm_pkg::spm_size_e            size;
    req = '0;
    void'($urandom(32'ha9c2));
    wait (arst_n === 1'b1);

    errs = n_errors;
    for (int unsigned w = 0; w < FillWords; w++)
      send(make_req(1'b1, spm_pkg::SIZE_WORD, 1'b0, spm_pkg::AddrWidth'(w * 4), $urandom));
    for (int unsigned w = 0; w < FillWords; w++)
      send(make_req(1'b0, spm_pkg::SIZE_WORD, 1'b0, spm_pkg::AddrWidth'(w * 4), '0));
    finish_test("fill", errs);

    errs = n_errors;
    for (int unsigned i = 0; i < SubStores; i++) begin
      rnd  = $urandom;
      size = rnd[9] ? spm_pkg::SIZE_HALF : spm_pkg::SIZE_BYTE;
      off  = rnd[9] ? {rnd[10], 1'b0} : rnd[11:10];
      send(make_req(1'b1, size, 1'b0, {rnd[8:0], off}, $urandom));
      touched[i] = {rnd[8:0], 2'b00};
    end
    for (int unsigned i = 0; i < SubStores; i++)
      send(make_req(1'b0, spm_pkg::SIZE_WORD, 1'b0, touched[i], '0));
    finish_test("sub_store", errs);

    errs = n_errors;
    for (int unsigned i = 0; i < SubLoads; i++) begin
      rnd  = $urandom;
      size = rnd[9] ? spm_pkg::SIZE_HALF : spm_pkg::SIZE_BYTE;
      off  = rnd[9] ? {rnd[10], 1'b0} : rnd[11:10];
      send(make_req(1'b0, size, rnd[12], {rnd[8:0], off}, '0));
    end
    finish_test("sub_load", errs);

    // Each misaligned access is followed by a load of the same word
    errs = n_errors;
    for (int unsigned i = 0; i < MisCount; i++) begin
      rnd  = $urandom;
      size = rnd[9] ? spm_pkg::SIZE_HALF : spm_pkg::SIZE_WORD;
      off  = rnd[9] ? {rnd[10], 1'b1} : ((rnd[11:10] == 2'b00) ? 2'b01 : rnd[11:10]);
      send(make_req(rnd[12], size, rnd[13], {rnd[8:0], off}, $urandom));
      send(make_req(1'b0, spm_pkg::SIZE_WORD, 1'b0, {rnd[8:0], 2'b00}, '0));
    end
    finish_test("misalign", errs);

    errs = n_errors;
    for (int unsigned h = 0; h < 4; h++) begin
      rnd    = $urandom;
      hot[h] = rnd[8:0];
    end
    for (int unsigned i = 0; i < StreamLen; i++) begin
      rnd  = $urandom;
      widx = (rnd[1:0] != 2'b00) ? hot[rnd[3:2]] : rnd[12:4];
      case (rnd[14:13])
        2'd0:    size = spm_pkg::SIZE_BYTE;
        2'd1:    size = spm_pkg::SIZE_HALF;
        default: size = spm_pkg::SIZE_WORD;
      endcase
      off = rnd[16:15];
      // Mostly aligned, with the odd misaligned access mixed in
      if (rnd[19:17] != 3'b000) begin
        if (size == spm_pkg::SIZE_HALF) off[0] = 1'b0;
        if (size == spm_pkg::SIZE_WORD) off = 2'b00;
      end
      send(make_req(rnd[20], size, rnd[21], {widx, off}, $urandom));
    end
    finish_test("stream", errs);

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
src/spm_pkg.sv
src/sram.sv
src/spm_req_stage.sv
src/spm_bank_array.sv
src/spm_resp_stage.sv
src/spm_top.sv
bench/spm_clkgen.sv
bench/spm_props.sv
bench/spm_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = spm_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
